// ==== rom_defs.svh ====
//**************************************************************************
// ROM access subsystem: global sizing and timing constants
// slot count, SDRAM word address width, offset reset and ready delay
//**************************************************************************

`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

// number of client slots sharing the SDRAM read port
`define ROM_NUM_SLOTS 4

// SDRAM address counts 32-bit words
`define ROM_SDRAM_AW 22

// cycles from end of reset/download until ready
`define ROM_READY_DLY 5

// base offset loaded into every slot at reset
`define ROM_OFFSET_RST 22'h0

`endif

// ==== rom_types_pkg.sv ====
//**************************************************************************
// ROM access types: vector typedefs for SDRAM words and addresses,
// slot indices and per-slot masks
//**************************************************************************

`include "rom_defs.svh"

package rom_types_pkg;

    // word address on the SDRAM read port
    typedef logic [`ROM_SDRAM_AW-1:0] sdram_addr_t;

    // one SDRAM read word, byte 0 in bits 7:0
    typedef logic [31:0] sdram_word_t;

    // slot number, 0 is highest priority
    typedef logic [$clog2(`ROM_NUM_SLOTS)-1:0] slot_idx_t;

    // one bit per slot
    typedef logic [`ROM_NUM_SLOTS-1:0] slot_mask_t;

endpackage

// ==== rom_ctrl_pkg.sv ====
//**************************************************************************
// ROM access control: state encodings of the arbiter FSM and of the
// per-slot cache FSM
//**************************************************************************

package rom_ctrl_pkg;

    // arbiter: idle, or one read in flight
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_WAIT = 1'b1
    } arb_state_t;

    // slot cache
    typedef enum logic [1:0] {
        SLOT_IDLE = 2'd0,  // no valid access presented
        SLOT_REQ  = 2'd1,  // miss, waiting on the arbiter
        SLOT_HIT  = 2'd2   // data served from the cached word
    } slot_state_t;

endpackage

// ==== rom_slot_if.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM slot link: request, word address and grant between a slot cache
// and the arbiter, plus the shared SDRAM read bus
//**************************************************************************

interface rom_slot_if (
    input rom_types_pkg::sdram_word_t data,      // shared read bus
    input logic                       data_rdy   // one-cycle pulse
);
    logic                       req;
    rom_types_pkg::sdram_addr_t word_addr;
    logic                       grant;

    modport slot (
        output req,
        output word_addr,
        input  grant,
        input  data,
        input  data_rdy
    );

    modport arb (
        input  req,
        input  word_addr,
        output grant
    );

endinterface

// ==== rom_slot_cache.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM slot cache: holds the last 32-bit word fetched for one slot,
// translates the slot address and requests misses from the arbiter
//**************************************************************************

module rom_slot_cache #(
    parameter int  DW = 8,
    localparam int AW = (DW == 8) ? 15 : (DW == 16) ? 14 : 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       cs,
    input  logic [AW-1:0]              addr,
    input  rom_types_pkg::sdram_addr_t offset,
    output logic [DW-1:0]              dout,
    output logic                       ok,
    rom_slot_if.slot                   bus
);
    // slot units per 32-bit word, as a shift
    localparam int SHIFT = (DW == 8) ? 2 : (DW == 16) ? 1 : 0;

    rom_ctrl_pkg::slot_state_t  state;
    rom_types_pkg::sdram_addr_t addr_w;      // translated word address
    rom_types_pkg::sdram_addr_t tag;
    rom_types_pkg::sdram_word_t cache_data;
    logic                       valid;
    logic                       hit;
    logic                       ok_q;
    logic [AW-1:0]              addr_last;
    logic [1:0]                 lane;        // byte or half-word within the word

    assign addr_w = rom_types_pkg::sdram_addr_t'(addr >> SHIFT) + offset;
    assign hit    = valid && (tag == addr_w);

    // little-endian lane select, always 0 for 32-bit slots
    assign lane = addr[1:0] & 2'((1 << SHIFT) - 1);
    assign dout = DW'(cache_data >> (DW * lane));

    // ok falls at once with cs or a new address
    assign ok = ok_q && cs && (addr == addr_last);

    always_ff @(posedge clk) begin
        addr_last <= addr;
        if (rst || flush) begin
            state   <= rom_ctrl_pkg::SLOT_IDLE;
            bus.req <= 1'b0;
            valid   <= 1'b0;
            ok_q    <= 1'b0;
        end else begin
            case (state)
                rom_ctrl_pkg::SLOT_IDLE,
                rom_ctrl_pkg::SLOT_HIT: begin
                    if (cs && hit) begin
                        state <= rom_ctrl_pkg::SLOT_HIT;
                        ok_q  <= 1'b1;
                    end else if (cs) begin
                        state         <= rom_ctrl_pkg::SLOT_REQ;  // miss
                        bus.req       <= 1'b1;
                        bus.word_addr <= addr_w;
                        ok_q          <= 1'b0;
                    end else begin
                        state <= rom_ctrl_pkg::SLOT_IDLE;
                        ok_q  <= 1'b0;
                    end
                end
                rom_ctrl_pkg::SLOT_REQ: begin
                    // only the granted slot takes the shared bus word
                    if (bus.grant && bus.data_rdy) begin
                        cache_data <= bus.data;
                        tag        <= bus.word_addr;
                        valid      <= 1'b1;
                        bus.req    <= 1'b0;
                        ok_q       <= cs && (addr_w == bus.word_addr);  // addr may have moved
                        state      <= rom_ctrl_pkg::SLOT_HIT;
                    end
                end
                default: state <= rom_ctrl_pkg::SLOT_IDLE;
            endcase
        end
    end

    // ok needs cs held over the previous cycle as well
    a_ok_needs_cs: assert property (
        @(posedge clk) disable iff (rst || flush)
        ok |-> (cs && $past(cs))
    );

endmodule

// ==== rom_offset_regs.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM offset registers: per-slot SDRAM base offsets, loaded by a
// single-cycle write strobe from the configuration port
//**************************************************************************

`include "rom_defs.svh"

module rom_offset_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_we,
    input  rom_types_pkg::slot_idx_t   cfg_slot,
    input  rom_types_pkg::sdram_addr_t cfg_offset,
    output rom_types_pkg::sdram_addr_t offset0,
    output rom_types_pkg::sdram_addr_t offset1,
    output rom_types_pkg::sdram_addr_t offset2,
    output rom_types_pkg::sdram_addr_t offset3
);
    rom_types_pkg::sdram_addr_t base [`ROM_NUM_SLOTS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROM_NUM_SLOTS; i++) begin
                base[i] <= rom_types_pkg::sdram_addr_t'(`ROM_OFFSET_RST);
            end
        end else if (cfg_we) begin
            base[cfg_slot] <= cfg_offset;  // no back-pressure
        end
    end

    // caches pick the new base up on their next miss
    assign offset0 = base[0];
    assign offset1 = base[1];
    assign offset2 = base[2];
    assign offset3 = base[3];

endmodule

// ==== rom_arbiter.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM arbiter: fixed-priority SDRAM read arbiter over the slot caches,
// with refresh enable during idle vblank and the power-up ready flag
//**************************************************************************

`include "rom_defs.svh"

module rom_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       downloading,
    input  logic                       vblank,
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    output logic                       flush,
    output logic                       sdram_req,
    output rom_types_pkg::sdram_addr_t sdram_addr,
    output logic                       refresh_en,
    output logic                       ready,
    rom_slot_if.arb                    slot0,
    rom_slot_if.arb                    slot1,
    rom_slot_if.arb                    slot2,
    rom_slot_if.arb                    slot3
);
    rom_ctrl_pkg::arb_state_t   state;
    rom_types_pkg::slot_mask_t  req_v;
    rom_types_pkg::slot_mask_t  gnt;
    rom_types_pkg::slot_mask_t  active;   // requesting and not yet served
    rom_types_pkg::slot_idx_t   sel_idx;
    rom_types_pkg::sdram_addr_t slot_addr [`ROM_NUM_SLOTS];
    logic [`ROM_READY_DLY-1:0]  ready_sr;

    assign flush = rst || downloading;

    assign req_v = {slot3.req, slot2.req, slot1.req, slot0.req};
    assign slot_addr[0] = slot0.word_addr;
    assign slot_addr[1] = slot1.word_addr;
    assign slot_addr[2] = slot2.word_addr;
    assign slot_addr[3] = slot3.word_addr;

    assign slot0.grant = gnt[0];
    assign slot1.grant = gnt[1];
    assign slot2.grant = gnt[2];
    assign slot3.grant = gnt[3];

    assign active = req_v & ~gnt;
    assign ready  = ready_sr[`ROM_READY_DLY-1];

    // lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `ROM_NUM_SLOTS - 1; i >= 0; i--) begin
            if (active[i]) sel_idx = rom_types_pkg::slot_idx_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            state      <= rom_ctrl_pkg::ARB_IDLE;
            gnt        <= '0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b1;
            ready_sr   <= '0;
        end else begin
            ready_sr   <= {ready_sr[`ROM_READY_DLY-2:0], 1'b1};
            refresh_en <= 1'b0;
            if (sdram_ack) sdram_req <= 1'b0;
            // new selection when idle or as the current word lands
            if (state == rom_ctrl_pkg::ARB_IDLE || data_rdy) begin
                if (|active) begin
                    gnt        <= rom_types_pkg::slot_mask_t'(1) << sel_idx;
                    sdram_addr <= slot_addr[sel_idx];
                    sdram_req  <= 1'b1;
                    state      <= rom_ctrl_pkg::ARB_WAIT;
                end else begin
                    gnt        <= '0;
                    state      <= rom_ctrl_pkg::ARB_IDLE;
                    refresh_en <= vblank;  // bus free
                end
            end
        end
    end

    // at most one grant, held only by a slot that still requests
    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (flush)
        $onehot0(gnt) && ((gnt & ~req_v) == '0)
    );

    // one SDRAM read in flight at a time
    a_no_req_in_wait: assert property (
        @(posedge clk) disable iff (flush)
        (state == rom_ctrl_pkg::ARB_WAIT && !data_rdy) |=> !$rose(sdram_req)
    );

endmodule

// ==== rom_access_top.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM access top: four read-only slots with word caches sharing one
// SDRAM read port through a fixed-priority arbiter
//**************************************************************************

module rom_access_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       downloading,
    input  logic                       vblank,
    // configuration port
    input  logic                       cfg_we,
    input  rom_types_pkg::slot_idx_t   cfg_slot,
    input  rom_types_pkg::sdram_addr_t cfg_offset,
    // client slots
    input  logic [14:0]                slot0_addr,  // 8-bit
    input  logic [14:0]                slot1_addr,  // 8-bit
    input  logic [13:0]                slot2_addr,  // 16-bit
    input  logic [11:0]                slot3_addr,  // 32-bit
    input  logic                       slot0_cs,
    input  logic                       slot1_cs,
    input  logic                       slot2_cs,
    input  logic                       slot3_cs,
    output logic [7:0]                 slot0_dout,
    output logic [7:0]                 slot1_dout,
    output logic [15:0]                slot2_dout,
    output logic [31:0]                slot3_dout,
    output logic                       slot0_ok,
    output logic                       slot1_ok,
    output logic                       slot2_ok,
    output logic                       slot3_ok,
    output logic                       ready,
    // SDRAM read port
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    input  rom_types_pkg::sdram_word_t data_read,
    output logic                       sdram_req,
    output rom_types_pkg::sdram_addr_t sdram_addr,
    output logic                       refresh_en
);
    logic                       flush;
    rom_types_pkg::sdram_addr_t offset0;
    rom_types_pkg::sdram_addr_t offset1;
    rom_types_pkg::sdram_addr_t offset2;
    rom_types_pkg::sdram_addr_t offset3;

    // read bus fans out to every slot
    rom_slot_if u_slot0_if (.data(data_read), .data_rdy(data_rdy));
    rom_slot_if u_slot1_if (.data(data_read), .data_rdy(data_rdy));
    rom_slot_if u_slot2_if (.data(data_read), .data_rdy(data_rdy));
    rom_slot_if u_slot3_if (.data(data_read), .data_rdy(data_rdy));

    rom_slot_cache #(.DW(8)) u_slot0 (
        .clk(clk), .rst(rst), .flush(flush), .cs(slot0_cs), .addr(slot0_addr),
        .offset(offset0), .dout(slot0_dout), .ok(slot0_ok), .bus(u_slot0_if.slot)
    );

    rom_slot_cache #(.DW(8)) u_slot1 (
        .clk(clk), .rst(rst), .flush(flush), .cs(slot1_cs), .addr(slot1_addr),
        .offset(offset1), .dout(slot1_dout), .ok(slot1_ok), .bus(u_slot1_if.slot)
    );

    rom_slot_cache #(.DW(16)) u_slot2 (
        .clk(clk), .rst(rst), .flush(flush), .cs(slot2_cs), .addr(slot2_addr),
        .offset(offset2), .dout(slot2_dout), .ok(slot2_ok), .bus(u_slot2_if.slot)
    );

    rom_slot_cache #(.DW(32)) u_slot3 (
        .clk(clk), .rst(rst), .flush(flush), .cs(slot3_cs), .addr(slot3_addr),
        .offset(offset3), .dout(slot3_dout), .ok(slot3_ok), .bus(u_slot3_if.slot)
    );

    rom_offset_regs u_offset_regs (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_slot(cfg_slot),
        .cfg_offset(cfg_offset), .offset0(offset0), .offset1(offset1),
        .offset2(offset2), .offset3(offset3)
    );

    rom_arbiter u_arbiter (
        .clk(clk), .rst(rst), .downloading(downloading), .vblank(vblank),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .flush(flush),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .refresh_en(refresh_en),
        .ready(ready), .slot0(u_slot0_if.arb), .slot1(u_slot1_if.arb),
        .slot2(u_slot2_if.arb), .slot3(u_slot3_if.arb)
    );

endmodule

// ==== tb_sdram_model.sv ====
`timescale 1ns/1ps
//**************************************************************************
// SDRAM read port model: random ack and data latency, the word at
// address A holds ~A[15:0] above A[15:0]
//**************************************************************************

module tb_sdram_model (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sdram_req,
    input  rom_types_pkg::sdram_addr_t sdram_addr,
    output logic                       sdram_ack,
    output logic                       data_rdy,
    output rom_types_pkg::sdram_word_t data_read
);
    integer                     seed;
    int                         phase;  // 0 idle, 1 before ack, 2 before data
    int                         cnt;
    logic                       ack_n;
    logic                       rdy_n;
    rom_types_pkg::sdram_addr_t addr_q;

    // 1 to 4 cycles
    function automatic int pick_delay();
        return 1 + int'($unsigned($random(seed)) % 4);
    endfunction

    initial begin
        seed      = 58;
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        data_read <= '0;
    end

    always @(posedge clk) begin
        ack_n = 1'b0;
        rdy_n = 1'b0;
        if (rst) begin
            phase = 0;
        end else if (phase == 0) begin
            if (sdram_req) begin
                addr_q = sdram_addr;
                cnt    = pick_delay();
                phase  = 1;
            end
        end else begin
            cnt = cnt - 1;
            if (cnt == 0 && phase == 1) begin
                ack_n = 1'b1;
                cnt   = pick_delay();
                phase = 2;
            end else if (cnt == 0) begin
                rdy_n = 1'b1;
                phase = 0;
                data_read <= #1 {~addr_q[15:0], addr_q[15:0]};
            end
        end
        sdram_ack <= #1 ack_n;
        data_rdy  <= #1 rdy_n;   // one-cycle pulse
    end

endmodule

// ==== tb_rom_access.sv ====
`timescale 1ns/1ps
//**************************************************************************
// ROM access testbench: table-driven slot reads, offset writes, priority,
// refresh and download checks against a random-latency SDRAM model
//**************************************************************************

module tb_rom_access;

    localparam int NUM_ROWS       = 14;
    localparam int ROW_LIMIT      = 30;  // cycles per slot to see ok
    localparam int RST_CYCLES     = 5;
    localparam int READY_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 30 + RST_CYCLES + READY_CYCLES;

    localparam int OP_READ     = 0;
    localparam int OP_PAIR     = 1;  // this row and the next start together
    localparam int OP_CFG      = 2;
    localparam int OP_VBLANK   = 3;
    localparam int OP_DOWNLOAD = 4;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       downloading;
    logic                       vblank;
    logic                       cfg_we;
    rom_types_pkg::slot_idx_t   cfg_slot;
    rom_types_pkg::sdram_addr_t cfg_offset;
    logic [14:0]                addr_v [4];
    logic [3:0]                 cs_v;
    logic [3:0]                 ok_v;
    logic [7:0]                 dout0;
    logic [7:0]                 dout1;
    logic [15:0]                dout2;
    logic [31:0]                dout3;
    logic [3:0][31:0]           dout_v;
    logic                       ready;
    logic                       sdram_req;
    logic                       sdram_ack;
    logic                       data_rdy;
    logic                       refresh_en;
    rom_types_pkg::sdram_addr_t sdram_addr;
    rom_types_pkg::sdram_word_t data_read;

    string       row_name  [NUM_ROWS];
    int          row_op    [NUM_ROWS];
    int          row_slot  [NUM_ROWS];
    logic [31:0] row_value [NUM_ROWS];  // slot address, offset or vblank level
    logic [31:0] row_exp   [NUM_ROWS];
    logic [31:0] row_addr  [NUM_ROWS];  // sdram_addr expected on a miss
    bit          row_miss  [NUM_ROWS];
    int          n_rows;
    int          errors;
    int          checks;
    int          cycles;

    always #2 clk = ~clk;

    assign dout_v = {dout3, 16'h0, dout2, 24'h0, dout1, 24'h0, dout0};

    rom_access_top u_rom_access_top (
        .clk(clk), .rst(rst), .downloading(downloading), .vblank(vblank),
        .cfg_we(cfg_we), .cfg_slot(cfg_slot), .cfg_offset(cfg_offset),
        .slot0_addr(addr_v[0]), .slot1_addr(addr_v[1]),
        .slot2_addr(addr_v[2][13:0]), .slot3_addr(addr_v[3][11:0]),
        .slot0_cs(cs_v[0]), .slot1_cs(cs_v[1]), .slot2_cs(cs_v[2]), .slot3_cs(cs_v[3]),
        .slot0_dout(dout0), .slot1_dout(dout1), .slot2_dout(dout2), .slot3_dout(dout3),
        .slot0_ok(ok_v[0]), .slot1_ok(ok_v[1]), .slot2_ok(ok_v[2]), .slot3_ok(ok_v[3]),
        .ready(ready), .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .refresh_en(refresh_en)
    );

    tb_sdram_model u_sdram (
        .clk(clk), .rst(rst || downloading), .sdram_req(sdram_req),
        .sdram_addr(sdram_addr), .sdram_ack(sdram_ack), .data_rdy(data_rdy),
        .data_read(data_read)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic add_row(string name, int op, int slot, logic [31:0] value,
                           logic [31:0] exp, logic [31:0] addr, bit miss);
        row_name[n_rows]  = name;
        row_op[n_rows]    = op;
        row_slot[n_rows]  = slot;
        row_value[n_rows] = value;
        row_exp[n_rows]   = exp;
        row_addr[n_rows]  = addr;
        row_miss[n_rows]  = miss;
        n_rows++;
    endtask

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic require(logic cond, string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR %s", what);
        end
    endtask

    task automatic check_flushed(string tag);
        require(!sdram_req, {tag, ": sdram_req not held low"});
        require(ok_v == 4'b0, {tag, ": a slot ok is high"});
        require(refresh_en, {tag, ": refresh_en not forced high"});
        require(!ready, {tag, ": ready not low"});
    endtask

    task automatic wait_ready_rise(string tag);
        int i;
        for (i = 1; i <= READY_CYCLES; i++) begin
            @(posedge clk);
            #1;
            if (i < READY_CYCLES) begin
                require(!ready, {tag, ": ready rose too early"});
            end else begin
                require(ready, {tag, ": ready not high 5 cycles after release"});
            end
        end
    endtask

    // n rows raise cs together, the first row is the highest priority
    task automatic run_access(int r, int n);
        int          wait_cnt;
        int          k;
        bit          req_seen;
        logic [1:0]  done;
        logic [1:0]  want;
        logic [31:0] first_addr;
        logic [31:0] got [2];
        wait_cnt   = 0;
        req_seen   = 1'b0;
        done       = 2'b00;
        want       = (n == 2) ? 2'b11 : 2'b01;
        first_addr = '0;
        for (k = 0; k < n; k++) begin
            addr_v[row_slot[r+k]] = row_value[r+k][14:0];
            cs_v[row_slot[r+k]]   = 1'b1;
        end
        while (done != want && wait_cnt < n * ROW_LIMIT) begin
            @(posedge clk);
            #1;
            wait_cnt++;
            if (sdram_req && !req_seen) begin
                req_seen   = 1'b1;
                first_addr = 32'(sdram_addr);
            end
            for (k = 0; k < n; k++) begin
                if (!done[k] && ok_v[row_slot[r+k]]) begin
                    done[k] = 1'b1;
                    got[k]  = dout_v[row_slot[r+k]];
                end
            end
        end
        for (k = 0; k < n; k++) begin
            require(done[k], {row_name[r+k], ": ok did not rise within the row limit"});
            compare_value(row_name[r+k], row_exp[r+k], got[k]);
            cs_v[row_slot[r+k]] = 1'b0;
        end
        if (row_miss[r]) begin
            require(req_seen, {row_name[r], ": no SDRAM request on a miss"});
            if (req_seen) begin
                compare_value({row_name[r], " sdram_addr"}, row_addr[r], first_addr);
            end
        end else begin
            require(!req_seen, {row_name[r], ": SDRAM request on a cache hit"});
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int r;
        rst         = 1'b1;
        downloading = 1'b0;
        vblank      = 1'b0;
        cfg_we      = 1'b0;
        cfg_slot    = '0;
        cfg_offset  = '0;
        cs_v        = '0;
        for (r = 0; r < 4; r++) begin
            addr_v[r] = '0;
        end
        // name, op, slot, addr/offset/vblank, data, sdram_addr, miss
        add_row("rd_s0_miss", OP_READ, 0, 32'h48D2, 32'hCB, 32'h1234, 1'b1);
        add_row("rd_s0_hit", OP_READ, 0, 32'h48D3, 32'hED, 32'h1234, 1'b0);
        add_row("rd_s1_miss", OP_READ, 1, 32'h2971, 32'h0A, 32'h0A5C, 1'b1);
        add_row("rd_s2_miss", OP_READ, 2, 32'h0EEF, 32'hF888, 32'h0777, 1'b1);
        add_row("rd_s2_hit", OP_READ, 2, 32'h0EEE, 32'h0777, 32'h0777, 1'b0);
        add_row("rd_s3_miss", OP_READ, 3, 32'h0ABC, 32'hF5430ABC, 32'h0ABC, 1'b1);
        add_row("cfg_s1_base", OP_CFG, 1, 32'h20100, 32'h0, 32'h0, 1'b0);
        add_row("rd_s1_new_base", OP_READ, 1, 32'h2971, 32'h0B, 32'h20B5C, 1'b1);
        add_row("pri_s0", OP_PAIR, 0, 32'h0C87, 32'hFC, 32'h0321, 1'b1);
        add_row("pri_s3", OP_READ, 3, 32'h0456, 32'hFBA90456, 32'h0456, 1'b1);
        add_row("refresh_vblank_hi", OP_VBLANK, 0, 32'h1, 32'h1, 32'h0, 1'b0);
        add_row("refresh_vblank_lo", OP_VBLANK, 0, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row("download", OP_DOWNLOAD, 0, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row("rd_s0_after_dl", OP_READ, 0, 32'h0C87, 32'hFC, 32'h0321, 1'b1);

        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            check_flushed("reset");
        end
        rst = 1'b0;
        wait_ready_rise("reset");

        r = 0;
        while (r < n_rows) begin
            case (row_op[r])
                OP_READ: run_access(r, 1);
                OP_PAIR: run_access(r, 2);
                OP_CFG: begin
                    cfg_we     = 1'b1;  // single-cycle strobe
                    cfg_slot   = rom_types_pkg::slot_idx_t'(row_slot[r]);
                    cfg_offset = rom_types_pkg::sdram_addr_t'(row_value[r]);
                    @(posedge clk);
                    #1;
                    cfg_we = 1'b0;
                end
                OP_VBLANK: begin
                    vblank = row_value[r][0];
                    repeat (2) begin
                        @(posedge clk);
                        #1;
                    end
                    compare_value(row_name[r], row_exp[r], 32'(refresh_en));
                end
                default: begin
                    downloading = 1'b1;
                    @(posedge clk);
                    #1;
                    check_flushed(row_name[r]);
                    downloading = 1'b0;
                    wait_ready_rise(row_name[r]);
                end
            endcase
            r = r + ((row_op[r] == OP_PAIR) ? 2 : 1);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
rom_types_pkg.sv
rom_ctrl_pkg.sv
rom_slot_if.sv
rom_slot_cache.sv
rom_offset_regs.sv
rom_arbiter.sv
rom_access_top.sv
tb_sdram_model.sv
tb_rom_access.sv

// ==== Makefile ====
# Verilator build and run of the ROM access testbench
SIM := obj_dir/Vtb_rom_access

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rom_access -f verilog.f
	$(SIM) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module rom_access_top -f verilog.f

clean:
	rm -rf obj_dir sim.log
